// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_pipeline_tb
FILELIST  ?= rv_pipeline.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	elif grep -q "Test passed" $(LOG); then \
		echo "simulation reported success"; \
	else \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/rv_pipeline_checker.sv
`timescale 1ns/10ps

module rv_pipeline_checker import rv_pkg::*; (
    input logic              clk,
    input logic              rst_n_i,
    input logic              instr_valid_i,
    input logic              wb_valid_o,
    input logic [REG_AW-1:0] wb_rd_o
);

    // ----------------------------------------
    // write-back port rules
    // ----------------------------------------
    // first reset edge clears the wb register, so look one edge back
    property quiet_in_reset;
        @(posedge clk) (!rst_n_i && $past(!rst_n_i)) |-> !wb_valid_o;
    endproperty

    property no_x0_write;
        @(posedge clk) disable iff (!rst_n_i)
            wb_valid_o |-> (wb_rd_o != '0);      // x0 never written back
    endproperty

    property fixed_latency;
        @(posedge clk) disable iff (!rst_n_i)
            wb_valid_o |-> $past(instr_valid_i, 3); // sampled 3 edges earlier
    endproperty

    assert property (quiet_in_reset)
        else $error("wb_valid_o high while reset is held");
    assert property (no_x0_write)
        else $error("write-back to x0 with wb_rd_o = %0d", wb_rd_o);
    assert property (fixed_latency)
        else $error("wb_valid_o without an instruction three cycles earlier");

endmodule

bind rv_pipeline rv_pipeline_checker rv_pipeline_checker_inst (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o)
);

// File: bench/rv_pipeline_tb.sv
`timescale 1ns/10ps

module rv_pipeline_tb import rv_pkg::*; ();

    localparam int DMEM_ADDR_W = 6;              // 64 words
    localparam int WB_LATENCY  = 3;              // edges from sample to wb_valid_o
    localparam int DRAIN_LIMIT = 200;            // cycles allowed for the queue to empty

    typedef struct packed {
        wb_t         wb;                         // expected rd and data
        logic [31:0] issue_edge;                 // edge count when driven
    } exp_item_t;

    logic              clk;
    logic              rst_n_i;
    logic              instr_valid_i;
    logic [XLEN-1:0]   instr_i;
    logic              wb_valid_o;
    logic [REG_AW-1:0] wb_rd_o;
    logic [XLEN-1:0]   wb_data_o;

    logic [31:0]            lfsr_q = 32'h2db0;
    logic [XLEN-1:0]        model_regs [32];     // reference register file
    logic [XLEN-1:0]        model_mem [2**DMEM_ADDR_W];
    logic [DMEM_ADDR_W-1:0] stored_words [$];    // words a load may use
    exp_item_t              exp_q [$];
    logic [REG_AW-1:0]      last_rd [2];         // rd of the two previous slots, 0 if none
    int                     edge_cnt  = 0;
    int                     err_cnt   = 0;
    int                     check_cnt = 0;
    int                     wb_cnt    = 0;

    rv_pipeline #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) rv_pipeline_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    always #5 clk = ~clk;                        // 10 ns period

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // ----------------------------------------
    // random source and encoders
    // ----------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1); // galois step
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [4:0] r;
        r = 5'(rand_bits(5));
        return (r == 5'd0) ? 5'd1 : r;           // never x0
    endfunction

    function automatic logic [2:0] alu_f3();
        case (rand_bits(3) % 5)
            0:       return 3'b000;              // add / sub
            1:       return 3'b010;              // slt
            2:       return 3'b100;              // xor
            3:       return 3'b110;              // or
            default: return 3'b111;              // and
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic sub, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [11:0] imm,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE}; // split immediate
    endfunction

    // immediate that lands base + imm on the given word, random upper bits wrap
    function automatic logic [11:0] addr_imm(input logic [4:0] base,
                                             input logic [DMEM_ADDR_W-1:0] word);
        logic [11:0] mask;
        logic [11:0] low;
        mask = 12'((1 << (DMEM_ADDR_W + 2)) - 1);
        low  = 12'({word, 2'b00}) - model_regs[base][11:0];
        return (12'(rand_bits(12)) & ~mask) | (low & mask);
    endfunction

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic wb_t ref_model(input logic [31:0] instr);
        logic [6:0]             opc;
        logic [2:0]             f3;
        logic [31:0]            a;
        logic [31:0]            b;
        logic [31:0]            imm_s;
        logic [31:0]            res;
        logic [DMEM_ADDR_W-1:0] idx;
        logic                   writes;
        wb_t                    exp;
        opc    = instr[6:0];
        f3     = instr[14:12];
        a      = model_regs[instr[19:15]];
        b      = (opc == OPC_OP) ? model_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
        imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        res    = '0;
        exp    = '0;
        writes = 1'b0;
        if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            writes = 1'b1;
            case (f3)
                3'b000:  res = (opc == OPC_OP && instr[30]) ? a - b : a + b;
                3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                3'b100:  res = a ^ b;
                3'b110:  res = a | b;
                3'b111:  res = a & b;
                default: writes = 1'b0;          // shifts, sltu
            endcase
        end else if (opc == OPC_LOAD && f3 == 3'b010) begin
            idx    = DMEM_ADDR_W'((a + b) >> 2);
            res    = model_mem[idx];
            writes = 1'b1;
        end else if (opc == OPC_STORE && f3 == 3'b010) begin
            idx            = DMEM_ADDR_W'((a + imm_s) >> 2);
            model_mem[idx] = model_regs[instr[24:20]];
            stored_words.push_back(idx);
        end
        if (writes && instr[11:7] != 5'd0) begin
            model_regs[instr[11:7]] = res;
            exp.valid = 1'b1;
            exp.rd    = instr[11:7];
            exp.data  = res;
        end
        return exp;
    endfunction

    // ----------------------------------------
    // drive and compare
    // ----------------------------------------
    function automatic logic reads_recent(input logic [4:0] r);
        return (r != 5'd0) && (r == last_rd[0] || r == last_rd[1]);
    endfunction

    task automatic bubble();
        @(negedge clk);
        instr_valid_i = 1'b0;
        instr_i       = rand_bits(32);           // junk, must be ignored
        last_rd[1]    = last_rd[0];
        last_rd[0]    = '0;
    endtask

    task automatic gap();
        int n;
        n = (rand_bits(1) != 0) ? 0 : int'(rand_bits(2));
        repeat (n) bubble();
    endtask

    task automatic issue(input logic [31:0] instr);
        logic      uses_rs2;
        exp_item_t item;
        uses_rs2 = (instr[6:0] == OPC_OP) || (instr[6:0] == OPC_STORE);
        while (reads_recent(instr[19:15]) || (uses_rs2 && reads_recent(instr[24:20]))) begin
            bubble();                            // no forwarding in the DUT
        end
        @(negedge clk);
        instr_valid_i   = 1'b1;
        instr_i         = instr;
        item.wb         = ref_model(instr);
        item.issue_edge = edge_cnt;
        if (item.wb.valid) begin
            exp_q.push_back(item);
        end
        last_rd[1] = last_rd[0];
        last_rd[0] = item.wb.valid ? item.wb.rd : '0;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    always @(negedge clk) begin : compare_wb
        exp_item_t item;
        if (rst_n_i && wb_valid_o) begin
            wb_cnt++;
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("write-back to x%0d arrived with no instruction expecting it", wb_rd_o);
            end else begin
                item = exp_q.pop_front();
                check_val("wb_rd_o", 32'(wb_rd_o), 32'(item.wb.rd));
                check_val("wb_data_o", wb_data_o, item.wb.data);
                check_val("wb_valid_o delay", edge_cnt - item.issue_edge, WB_LATENCY);
            end
        end else if (exp_q.size() != 0 && edge_cnt - exp_q[0].issue_edge > WB_LATENCY + 4) begin
            err_cnt++;
            $display("no write-back for x%0d within the timeout", exp_q[0].wb.rd);
            item = exp_q.pop_front();
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin : stimulus
        logic [4:0]             rd_a;
        logic [4:0]             rd_b;
        logic [4:0]             rs_a;
        logic [2:0]             f3;
        logic [DMEM_ADDR_W-1:0] w;
        int                     wait_cnt;
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        model_regs    = '{default: '0};
        last_rd       = '{default: '0};
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        repeat (40) begin                        // immediate alu, negative imm included
            issue(enc_i(OPC_OP_IMM, 12'(rand_bits(12)), 5'(rand_bits(5)), alu_f3(), rand_reg()));
            gap();
        end
        repeat (40) begin                        // register alu on earlier results
            f3 = alu_f3();
            issue(enc_r(f3 == 3'b000 && rand_bits(1) != 0, 5'(rand_bits(5)),
                        5'(rand_bits(5)), f3, rand_reg()));
            gap();
        end
        repeat (16) begin                        // store then load the same word
            w    = DMEM_ADDR_W'(rand_bits(DMEM_ADDR_W));
            rs_a = 5'(rand_bits(5));
            issue(enc_s(addr_imm(rs_a, w), 5'(rand_bits(5)), rs_a));
            rs_a = 5'(rand_bits(5));
            issue(enc_i(OPC_LOAD, addr_imm(rs_a, w), rs_a, F3_WORD, rand_reg()));
            w    = stored_words[rand_bits(8) % stored_words.size()]; // older word
            rs_a = 5'(rand_bits(5));
            issue(enc_i(OPC_LOAD, addr_imm(rs_a, w), rs_a, F3_WORD, rand_reg()));
            gap();
        end
        repeat (8) begin                         // back to back, distinct rd
            rd_a = rand_reg();
            rd_b = rd_a % 5'd31 + 5'd1;
            issue(enc_i(OPC_OP_IMM, 12'(rand_bits(12)), 5'd0, alu_f3(), rd_a));
            issue(enc_i(OPC_OP_IMM, 12'(rand_bits(12)), 5'd0, alu_f3(), rd_b));
            issue(enc_i(OPC_OP_IMM, 12'(rand_bits(12)), 5'd0, alu_f3(), rd_b % 5'd31 + 5'd1));
        end
        // no write-back expected from these
        issue(enc_i(OPC_OP_IMM, 12'(rand_bits(12)), rand_reg(), F3_ADD, 5'd0));
        issue(enc_r(1'b0, rand_reg(), rand_reg(), F3_OR, 5'd0));
        issue(enc_i(7'b1100011, 12'(rand_bits(12)), rand_reg(), 3'b000, rand_reg())); // branch
        issue(enc_r(1'b0, rand_reg(), rand_reg(), 3'b001, rand_reg()));               // sll
        issue(enc_i(OPC_LOAD, 12'd0, 5'd0, 3'b000, rand_reg()));                      // lb
        issue(enc_r(1'b0, 5'd0, 5'd0, F3_ADD, rand_reg()));   // x0 reads zero
        issue(enc_i(OPC_OP_IMM, 12'd0, 5'd0, F3_OR, rand_reg()));
        bubble();

        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("timed out with %0d write-backs still outstanding", exp_q.size());
        end
        repeat (WB_LATENCY + 1) @(negedge clk);  // catch a stray late write-back
        $display("checks %0d, write-backs %0d, errors %0d", check_cnt, wb_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: rtl/rv_decode.sv
`timescale 1ns/10ps

module rv_decode import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            instr_valid_i,       // one instr per strobe
    input  logic [XLEN-1:0] instr_i,
    input  wb_t             wb_i,                // write-back from memory stage
    output dec_ex_t         dec_o
);

    // ----------------------------------------
    // field registers
    // ----------------------------------------
    logic              valid_q;
    logic [6:0]        opcode_q;
    logic [2:0]        funct3_q;
    logic              funct7b5_q;               // sub vs add
    logic [REG_AW-1:0] rs1_q;
    logic [REG_AW-1:0] rs2_q;
    logic [REG_AW-1:0] rd_q;
    logic [XLEN-1:0]   imm_q;

    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        opcode_q   <= instr_i[6:0];
        funct3_q   <= instr_i[14:12];
        funct7b5_q <= instr_i[30];
        rs1_q      <= instr_i[19:15];
        rs2_q      <= instr_i[24:20];
        rd_q       <= instr_i[11:7];
        if (instr_i[6:0] == OPC_STORE) begin     // s-format split immediate
            imm_q <= {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        end else begin                           // i-format
            imm_q <= {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
        end
    end

    // ----------------------------------------
    // control decode
    // ----------------------------------------
    alu_op_e alu_op;
    logic    supported;                          // clear turns item into bubble
    logic    is_alu;
    logic    mem_read;
    logic    mem_write;

    always_comb begin
        alu_op    = ALU_ADD;                     // loads and stores add
        supported = 1'b0;
        is_alu    = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        case (opcode_q)
            OPC_OP, OPC_OP_IMM: begin
                is_alu    = 1'b1;
                supported = 1'b1;
                case (funct3_q)
                    F3_ADD:  alu_op = (opcode_q == OPC_OP && funct7b5_q) ? ALU_SUB : ALU_ADD;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: supported = 1'b0;   // shifts, sltu not handled
                endcase
            end
            OPC_LOAD: begin
                mem_read  = 1'b1;
                supported = (funct3_q == F3_WORD); // word access only
            end
            OPC_STORE: begin
                mem_write = 1'b1;
                supported = (funct3_q == F3_WORD);
            end
            default: supported = 1'b0;
        endcase
    end

    rv_regfile rv_regfile_inst (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (rs1_q),                       // registered addresses
        .raddr2_i (rs2_q),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .wb_i     (wb_i)
    );

    assign dec_o.valid     = valid_q && supported;
    assign dec_o.alu_op    = alu_op;
    assign dec_o.use_imm   = (opcode_q != OPC_OP); // only r-type uses rs2
    assign dec_o.mem_read  = mem_read;
    assign dec_o.mem_write = mem_write;
    assign dec_o.reg_write = (is_alu || mem_read) && (rd_q != '0); // x0 never written
    assign dec_o.rd        = rd_q;
    assign dec_o.rs1_data  = rs1_data;
    assign dec_o.rs2_data  = rs2_data;
    assign dec_o.imm       = imm_q;

endmodule

// File: rtl/rv_execute.sv
`timescale 1ns/10ps

module rv_execute import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  dec_ex_t dec_i,                       // from decode
    output ex_mem_t ex_o                         // to memory stage
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    logic            lt_signed;

    ex_mem_t ex_q;

    // ----------------------------------------
    // alu
    // ----------------------------------------
    assign op_a      = dec_i.rs1_data;
    assign op_b      = dec_i.use_imm ? dec_i.imm : dec_i.rs2_data; // imm or rs2
    assign lt_signed = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD: result = op_a + op_b;       // also lw/sw address
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, lt_signed};
            default: result = '0;
        endcase
    end

    // ----------------------------------------
    // stage register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_q.valid <= 1'b0;                  // pipeline empty after reset
        end else begin
            ex_q.valid <= dec_i.valid;
        end
    end

    // payload and flags, qualified downstream by valid
    always_ff @(posedge clk) begin
        ex_q.mem_read   <= dec_i.mem_read;
        ex_q.mem_write  <= dec_i.mem_write;
        ex_q.reg_write  <= dec_i.reg_write;
        ex_q.rd         <= dec_i.rd;
        ex_q.result     <= result;
        ex_q.store_data <= dec_i.rs2_data;       // sw data is always rs2
    end

    assign ex_o = ex_q;

endmodule

// File: rtl/rv_memory.sv
`timescale 1ns/10ps

module rv_memory import rv_pkg::*; #(
    parameter int DMEM_ADDR_W = 6                // word address width, 64 words
) (
    input  logic    clk,
    input  logic    rst_n_i,
    input  ex_mem_t ex_i,                        // from execute
    output wb_t     wb_o                         // write-back item
);

    localparam int DMEM_WORDS = 2 ** DMEM_ADDR_W;

    logic [XLEN-1:0]        dmem [DMEM_WORDS];   // data memory, no reset
    logic [DMEM_ADDR_W-1:0] word_addr;
    wb_t                    wb_q;

    // byte address to word index, upper bits wrap
    assign word_addr = ex_i.result[DMEM_ADDR_W+1:2];

    // ----------------------------------------
    // store port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (ex_i.valid && ex_i.mem_write) begin
            dmem[word_addr] <= ex_i.store_data;
        end
    end

    // ----------------------------------------
    // write-back register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q.valid <= ex_i.valid && ex_i.reg_write; // stores, bubbles drop here
        end
    end

    always_ff @(posedge clk) begin
        wb_q.rd <= ex_i.rd;
        if (ex_i.mem_read) begin
            wb_q.data <= dmem[word_addr];        // lw result
        end else begin
            wb_q.data <= ex_i.result;            // alu result
        end
    end

    assign wb_o = wb_q;

endmodule

// File: rtl/rv_pipeline.sv
`timescale 1ns/10ps

module rv_pipeline import rv_pkg::*; #(
    parameter int DMEM_ADDR_W = 6                // data memory word address bits
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              instr_valid_i,     // instr_i qualifier
    input  logic [XLEN-1:0]   instr_i,
    output logic              wb_valid_o,        // register write this cycle
    output logic [REG_AW-1:0] wb_rd_o,
    output logic [XLEN-1:0]   wb_data_o
);

    // ----------------------------------------
    // stage links
    // ----------------------------------------
    dec_ex_t dec_ex;                             // decode -> execute
    ex_mem_t ex_mem;                             // execute -> memory
    wb_t     wb;                                 // memory -> out and regfile

    // decode, registers fields and owns the regfile
    rv_decode rv_decode_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_i          (wb),                     // write-back loop
        .dec_o         (dec_ex)
    );

    // execute, alu
    rv_execute rv_execute_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .dec_i   (dec_ex),
        .ex_o    (ex_mem)
    );

    // memory, data ram and write-back register
    rv_memory #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) rv_memory_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ex_i    (ex_mem),
        .wb_o    (wb)
    );

    // ----------------------------------------
    // outputs
    // ----------------------------------------
    // 3 edges after the instruction is sampled
    assign wb_valid_o = wb.valid;
    assign wb_rd_o    = wb.rd;
    assign wb_data_o  = wb.data;

endmodule

// File: rtl/rv_pkg.sv
package rv_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int XLEN   = 32;                  // data path width
    localparam int REG_AW = 5;                   // register address width

    // ----------------------------------------
    // opcodes and funct3 codes
    // ----------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011; // r-type alu
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // i-type alu
    localparam logic [6:0] OPC_LOAD   = 7'b0000011; // lw only
    localparam logic [6:0] OPC_STORE  = 7'b0100011; // sw only

    localparam logic [2:0] F3_ADD  = 3'b000;     // add, sub, addi
    localparam logic [2:0] F3_SLT  = 3'b010;     // slt, slti
    localparam logic [2:0] F3_XOR  = 3'b100;     // xor, xori
    localparam logic [2:0] F3_OR   = 3'b110;     // or, ori
    localparam logic [2:0] F3_AND  = 3'b111;     // and, andi
    localparam logic [2:0] F3_WORD = 3'b010;     // lw / sw width

    // ----------------------------------------
    // alu operations
    // ----------------------------------------
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,                          // also address calc
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5                           // signed compare
    } alu_op_e;

    // ----------------------------------------
    // stage payloads
    // ----------------------------------------
    typedef struct packed {
        logic              valid;                // live instruction
        alu_op_e           alu_op;
        logic              use_imm;              // imm replaces rs2
        logic              mem_read;             // lw
        logic              mem_write;            // sw
        logic              reg_write;            // rd != 0 and writes
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [XLEN-1:0]   imm;                  // already sign extended
    } dec_ex_t;

    typedef struct packed {
        logic              valid;
        logic              mem_read;
        logic              mem_write;
        logic              reg_write;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   result;               // alu value or byte address
        logic [XLEN-1:0]   store_data;           // rs2 for sw
    } ex_mem_t;

    typedef struct packed {
        logic              valid;                // set only for real writes
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } wb_t;

endpackage

// File: rtl/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile import rv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [REG_AW-1:0] raddr1_i,          // rs1 address
    input  logic [REG_AW-1:0] raddr2_i,          // rs2 address
    output logic [XLEN-1:0]   rdata1_o,          // rs1 data, combinational
    output logic [XLEN-1:0]   rdata2_o,          // rs2 data, combinational
    input  wb_t               wb_i               // write port
);

    localparam int NREGS = 2 ** REG_AW;          // 32 architectural regs

    // x0 has no storage
    logic [XLEN-1:0] regs_q [1:NREGS-1];

    // ----------------------------------------
    // write port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NREGS; i++) begin
                regs_q[i] <= '0;                 // all regs start at zero
            end
        end else if (wb_i.valid && (wb_i.rd != '0)) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    // ----------------------------------------
    // read ports
    // ----------------------------------------
    // new data visible the cycle after the write edge
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i]; // x0 reads zero
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

// File: rv_pipeline.f
rtl/rv_pkg.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_memory.sv
rtl/rv_pipeline.sv
bench/rv_pipeline_checker.sv
bench/rv_pipeline_tb.sv
